/* Makefile */
VERILATOR ?= verilator
TOP       ?= rename_core_tb
RTL_TOP   ?= rename_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

LINT_SRCS = $(filter-out verif/%,$(filter-out +%,$(shell cat $(FILELIST))))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '** PASS **' $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall +incdir+common $(LINT_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/rename_cfg.svh */
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// architectural and physical register file sizes
`define RN_ARF_DEPTH 32
`define RN_PRF_DEPTH 64

// execution lanes, one bus channel each
`define RN_CDB_WIDTH 2

`define RN_ROB_DEPTH 16 // power of two, pointers wrap
`define RN_LANE_LAT  3  // cycles from accept to broadcast, at least 1

`endif

/* common/rename_pkg.sv */
`include "rename_cfg.svh"

package rename_pkg;

    // architectural register index
    typedef logic [$clog2(`RN_ARF_DEPTH)-1:0] arch_idx_t;

    // physical register index, also the broadcast tag
    typedef logic [$clog2(`RN_PRF_DEPTH)-1:0] phy_idx_t;

    // reorder buffer slot
    typedef logic [$clog2(`RN_ROB_DEPTH)-1:0] rob_idx_t;

    // occupancy count, one bit wider so a full buffer can be told from an empty one
    typedef logic [$clog2(`RN_ROB_DEPTH):0] rob_cnt_t;

    // execution lane select
    typedef logic [$clog2(`RN_CDB_WIDTH)-1:0] lane_idx_t;

endpackage

/* filelist.f */
+incdir+common
common/rename_pkg.sv
rat/rat.sv
rat/rrf.sv
verilog/free_list.sv
verilog/exec_lane.sv
verilog/rob.sv
verilog/rename_core.sv
verif/rename_core_tb.sv

/* rat/rat.sv */
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rat (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  rename_pkg::phy_idx_t  rrf_map [`RN_ARF_DEPTH],

    input  rename_pkg::arch_idx_t read_arch0,
    input  rename_pkg::arch_idx_t read_arch1,
    input  rename_pkg::arch_idx_t dest_arch,
    input  logic                  write_en,
    input  rename_pkg::phy_idx_t  write_phy,

    input  logic [`RN_CDB_WIDTH-1:0] cdb_valid,
    input  rename_pkg::arch_idx_t cdb_arch [`RN_CDB_WIDTH],
    input  rename_pkg::phy_idx_t  cdb_phy [`RN_CDB_WIDTH],

    output rename_pkg::phy_idx_t  read_phy0,
    output rename_pkg::phy_idx_t  read_phy1,
    output rename_pkg::phy_idx_t  old_phy,
    output logic                  read_ready0,
    output logic                  read_ready1
);
    import rename_pkg::*;

    phy_idx_t                  map_phy [`RN_ARF_DEPTH];
    logic [`RN_ARF_DEPTH-1:0]  map_ready;
    logic [`RN_CDB_WIDTH-1:0]  cdb_hit; // broadcast still matches the current mapping

    always_comb begin
        for (int i = 0; i < `RN_CDB_WIDTH; i++) begin
            cdb_hit[i] = cdb_valid[i] && (map_phy[cdb_arch[i]] == cdb_phy[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RN_ARF_DEPTH; i++) begin
                map_phy[i]   <= phy_idx_t'(i); // identity
                map_ready[i] <= 1'b1;
            end
        end else if (flush) begin
            for (int i = 0; i < `RN_ARF_DEPTH; i++) begin
                map_phy[i]   <= rrf_map[i];
                map_ready[i] <= 1'b1;
            end
        end else begin
            for (int i = 0; i < `RN_CDB_WIDTH; i++) begin
                if (cdb_hit[i])
                    map_ready[cdb_arch[i]] <= 1'b1;
            end
            // a new mapping wins over a wakeup of the old one
            if (write_en) begin
                map_phy[dest_arch]   <= write_phy;
                map_ready[dest_arch] <= 1'b0;
            end
        end
    end

    always_comb begin
        read_phy0   = map_phy[read_arch0];
        read_phy1   = map_phy[read_arch1];
        read_ready0 = map_ready[read_arch0];
        read_ready1 = map_ready[read_arch1];
        old_phy     = map_phy[dest_arch];
        for (int i = 0; i < `RN_CDB_WIDTH; i++) begin
            if (cdb_hit[i] && cdb_arch[i] == read_arch0) read_ready0 = 1'b1; // bypass
            if (cdb_hit[i] && cdb_arch[i] == read_arch1) read_ready1 = 1'b1;
        end
        // r0 is hardwired
        if (read_arch0 == '0) begin
            read_phy0   = '0;
            read_ready0 = 1'b1;
        end
        if (read_arch1 == '0) begin
            read_phy1   = '0;
            read_ready1 = 1'b1;
        end
        if (dest_arch == '0)
            old_phy = '0;
    end

    a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
        write_en |-> dest_arch != '0);

endmodule

/* rat/rrf.sv */
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rrf (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  commit_en,
    input  rename_pkg::arch_idx_t commit_arch,
    input  rename_pkg::phy_idx_t  commit_phy,
    output rename_pkg::phy_idx_t  rrf_map [`RN_ARF_DEPTH]
);
    import rename_pkg::*;

    phy_idx_t map_q [`RN_ARF_DEPTH];

    // committed state only, retirement is the single writer
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RN_ARF_DEPTH; i++) begin
                map_q[i] <= phy_idx_t'(i);
            end
        end else if (commit_en) begin
            map_q[commit_arch] <= commit_phy;
        end
    end

    always_comb begin
        for (int i = 0; i < `RN_ARF_DEPTH; i++) begin
            rrf_map[i] = map_q[i];
        end
    end

endmodule

/* verif/rename_core_tb.sv */
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_core_tb;
    import rename_pkg::*;

    typedef struct packed {
        arch_idx_t arch;
        phy_idx_t  phy;
        phy_idx_t  old;
        lane_idx_t lane;
        int        bcast;   // cycle in which the lane drives the bus
    } rob_ent_t;

    // reset, reset_state, rename, wakeup, commit, backpressure, flush
    localparam int test_cycles = 6 * 8 + 37 + 10 + 12 + 37 + 22 + 24;

    logic      clk = 1'b0;
    logic      rst;
    logic      flush;
    logic      inst_valid;
    logic      inst_ready;
    arch_idx_t inst_rd;
    arch_idx_t inst_rs1;
    arch_idx_t inst_rs2;
    lane_idx_t inst_lane;
    logic      ren_valid;
    phy_idx_t  ren_rd_phy;
    phy_idx_t  ren_rs1_phy;
    phy_idx_t  ren_rs2_phy;
    logic      ren_rs1_ready;
    logic      ren_rs2_ready;
    logic [`RN_CDB_WIDTH-1:0] cdb_valid;
    phy_idx_t  cdb_phy [`RN_CDB_WIDTH];
    logic      commit_valid;
    arch_idx_t commit_arch;
    phy_idx_t  commit_phy;

    // reference model
    phy_idx_t                 spec_map [`RN_ARF_DEPTH];
    logic [`RN_ARF_DEPTH-1:0] spec_rdy;
    phy_idx_t                 ret_map [`RN_ARF_DEPTH];
    logic [`RN_PRF_DEPTH-1:0] free_bits;
    rob_ent_t                 rob_q [$];
    logic [`RN_CDB_WIDTH-1:0] bc_valid;
    arch_idx_t                bc_arch [`RN_CDB_WIDTH];
    phy_idx_t                 bc_phy [`RN_CDB_WIDTH];
    phy_idx_t                 exp_rd;
    phy_idx_t                 exp_rs1;
    phy_idx_t                 exp_rs2;
    logic                     exp_rdy1;
    logic                     exp_rdy2;

    int    cyc;
    int    seed = 32'h76f6;
    int    value_errors = 0;
    int    other_errors = 0;
    string cur_test = "init";

    always #5 clk = ~clk;

    rename_core rename_core_inst (
        .clk(clk), .rst(rst), .flush(flush),
        .inst_valid(inst_valid), .inst_ready(inst_ready), .inst_rd(inst_rd),
        .inst_rs1(inst_rs1), .inst_rs2(inst_rs2), .inst_lane(inst_lane),
        .ren_valid(ren_valid), .ren_rd_phy(ren_rd_phy), .ren_rs1_phy(ren_rs1_phy),
        .ren_rs2_phy(ren_rs2_phy), .ren_rs1_ready(ren_rs1_ready),
        .ren_rs2_ready(ren_rs2_ready), .cdb_valid(cdb_valid), .cdb_phy(cdb_phy),
        .commit_valid(commit_valid), .commit_arch(commit_arch), .commit_phy(commit_phy)
    );

    task automatic check_phy(input string what, input phy_idx_t exp, input phy_idx_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error [%s] %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_arch(input string what, input arch_idx_t exp, input arch_idx_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error [%s] %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error [%s] %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    function automatic phy_idx_t src_phy(arch_idx_t a);
        return (a == '0) ? '0 : spec_map[a];
    endfunction

    function automatic logic src_ready(arch_idx_t a);
        logic r;
        r = spec_rdy[a] || (a == '0);
        for (int l = 0; l < `RN_CDB_WIDTH; l++) begin
            if (bc_valid[l] && bc_arch[l] == a && spec_map[a] == bc_phy[l])
                r = 1'b1; // same-cycle wakeup
        end
        return r;
    endfunction

    function automatic phy_idx_t lowest_free();
        for (int i = 0; i < `RN_PRF_DEPTH; i++) begin
            if (free_bits[i])
                return phy_idx_t'(i);
        end
        return '0;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < `RN_ARF_DEPTH; i++) begin
            spec_map[i] = phy_idx_t'(i);
            ret_map[i]  = phy_idx_t'(i);
        end
        spec_rdy = '1;
        for (int i = 0; i < `RN_PRF_DEPTH; i++) begin
            free_bits[i] = (i >= `RN_ARF_DEPTH);
        end
        rob_q.delete();
        cyc = 0;
    endtask

    // one clock cycle: check this cycle's outputs, advance the model, check ren_* after the edge
    task automatic step(output logic acc);
        logic     exp_ready;
        logic     exp_commit;
        rob_ent_t ent;
        #1;
        exp_ready = rob_q.size() < `RN_ROB_DEPTH && (free_bits != '0 || inst_rd == '0) && !flush;
        exp_commit = 1'b0;
        if (rob_q.size() > 0 && !flush)
            exp_commit = rob_q[0].bcast < cyc; // done bit is set at the broadcast edge
        bc_valid = '0;
        foreach (rob_q[i]) begin
            if (rob_q[i].bcast == cyc) begin
                bc_valid[rob_q[i].lane] = 1'b1;
                bc_arch[rob_q[i].lane]  = rob_q[i].arch;
                bc_phy[rob_q[i].lane]   = rob_q[i].phy;
            end
        end
        check_bit("inst_ready", exp_ready, inst_ready);
        for (int l = 0; l < `RN_CDB_WIDTH; l++) begin
            check_bit("cdb_valid", bc_valid[l], cdb_valid[l]);
            if (bc_valid[l])
                check_phy("cdb_phy", bc_phy[l], cdb_phy[l]);
        end
        check_bit("commit_valid", exp_commit, commit_valid);
        if (exp_commit) begin
            check_arch("commit_arch", rob_q[0].arch, commit_arch);
            check_phy("commit_phy", rob_q[0].phy, commit_phy);
        end

        acc = inst_valid && exp_ready;
        if (acc) begin
            exp_rs1   = src_phy(inst_rs1);
            exp_rs2   = src_phy(inst_rs2);
            exp_rdy1  = src_ready(inst_rs1);
            exp_rdy2  = src_ready(inst_rs2);
            ent.arch  = inst_rd;
            ent.phy   = '0;
            ent.old   = '0;
            ent.lane  = inst_lane;
            ent.bcast = cyc + `RN_LANE_LAT;
            if (inst_rd != '0) begin
                ent.phy = lowest_free();
                ent.old = spec_map[inst_rd];
            end
            exp_rd = ent.phy;
        end

        if (flush) begin
            spec_rdy  = '1;
            free_bits = '1;
            for (int i = 0; i < `RN_ARF_DEPTH; i++) begin
                spec_map[i]           = ret_map[i];
                free_bits[ret_map[i]] = 1'b0;
            end
            rob_q.delete();
        end else begin
            for (int l = 0; l < `RN_CDB_WIDTH; l++) begin
                if (bc_valid[l] && spec_map[bc_arch[l]] == bc_phy[l])
                    spec_rdy[bc_arch[l]] = 1'b1;
            end
            if (exp_commit) begin
                if (rob_q[0].arch != '0) begin
                    ret_map[rob_q[0].arch]  = rob_q[0].phy;
                    free_bits[rob_q[0].old] = 1'b1;
                end
                rob_q.delete(0);
            end
            if (acc) begin
                if (inst_rd != '0) begin
                    free_bits[ent.phy] = 1'b0;
                    spec_map[inst_rd]  = ent.phy; // new mapping wins over a wakeup
                    spec_rdy[inst_rd]  = 1'b0;
                end
                rob_q.push_back(ent);
            end
        end

        @(posedge clk);
        @(negedge clk);
        cyc++;
        check_bit("ren_valid", acc, ren_valid);
        if (acc) begin
            check_phy("ren_rd_phy", exp_rd, ren_rd_phy);
            check_phy("ren_rs1_phy", exp_rs1, ren_rs1_phy);
            check_phy("ren_rs2_phy", exp_rs2, ren_rs2_phy);
            check_bit("ren_rs1_ready", exp_rdy1, ren_rs1_ready);
            check_bit("ren_rs2_ready", exp_rdy2, ren_rs2_ready);
        end
    endtask

    task automatic do_reset();
        rst        = 1'b1;
        flush      = 1'b0;
        inst_valid = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        reset_model();
    endtask

    task automatic idle(input int n);
        logic acc;
        inst_valid = 1'b0;
        repeat (n) step(acc);
    endtask

    task automatic apply_inst(input arch_idx_t rd, input arch_idx_t rs1, input arch_idx_t rs2,
                              input lane_idx_t lane);
        logic acc;
        int   stalls;
        inst_valid = 1'b1;
        inst_rd    = rd;
        inst_rs1   = rs1;
        inst_rs2   = rs2;
        inst_lane  = lane;
        stalls     = 0;
        step(acc);
        while (!acc && stalls < 16) begin
            stalls++;
            step(acc);
        end
        if (!acc) begin
            other_errors++;
            $display("[%s] instruction was never accepted", cur_test);
        end
        inst_valid = 1'b0;
    endtask

    task automatic test_reset_state();
        cur_test = "reset_state";
        do_reset();
        for (int i = 0; i < `RN_ARF_DEPTH; i++) begin
            apply_inst('0, arch_idx_t'(i), arch_idx_t'(`RN_ARF_DEPTH - 1 - i), '0);
            check_phy("rs1 identity", phy_idx_t'(i), ren_rs1_phy);
            check_phy("rs2 identity", phy_idx_t'(`RN_ARF_DEPTH - 1 - i), ren_rs2_phy);
            check_bit("rs1 ready", 1'b1, ren_rs1_ready);
            check_bit("rs2 ready", 1'b1, ren_rs2_ready);
        end
        idle(`RN_LANE_LAT + 2);
    endtask

    task automatic test_rename();
        cur_test = "rename";
        do_reset();
        apply_inst(4, 1, 2, 0);
        check_phy("lowest free", 32, ren_rd_phy);
        apply_inst(6, 4, 0, 1);
        check_phy("next free", 33, ren_rd_phy);
        check_phy("rs1 renamed", 32, ren_rs1_phy);
        check_bit("rs1 waits", 1'b0, ren_rs1_ready);
        apply_inst(0, 6, 4, 0);
        check_phy("r0 dest", 0, ren_rd_phy);
        apply_inst(7, 0, 0, 1);
        check_phy("r0 took nothing", 34, ren_rd_phy);
        idle(`RN_LANE_LAT + 3);
    endtask

    task automatic test_wakeup();
        cur_test = "wakeup";
        do_reset();
        apply_inst(5, 0, 0, 0);     // p32 on lane 0
        apply_inst(5, 0, 0, 1);     // p33 replaces it on lane 1
        check_bit("cdb too early", 1'b0, cdb_valid[0]);
        apply_inst(0, 5, 0, 0);
        check_bit("rs1 waits", 1'b0, ren_rs1_ready);
        check_bit("cdb on time", 1'b1, cdb_valid[0]);
        check_phy("cdb tag", 32, cdb_phy[0]);
        apply_inst(0, 5, 0, 1);
        check_bit("stale broadcast", 1'b0, ren_rs1_ready);
        check_bit("lane 1 on time", 1'b1, cdb_valid[1]);
        apply_inst(0, 5, 0, 0);
        check_phy("rs1 mapping", 33, ren_rs1_phy);
        check_bit("transparent read", 1'b1, ren_rs1_ready);
        apply_inst(0, 5, 5, 1);
        check_bit("rs1 stays ready", 1'b1, ren_rs1_ready);
        check_bit("rs2 stays ready", 1'b1, ren_rs2_ready);
        idle(`RN_LANE_LAT + 3);
    endtask

    task automatic test_commit();
        cur_test = "commit";
        do_reset();
        apply_inst(3, 1, 2, 0);
        check_phy("first alloc", 32, ren_rd_phy);
        idle(`RN_LANE_LAT + 2);
        apply_inst(7, 3, 0, 1);
        check_phy("old p3 reused", 3, ren_rd_phy);
        check_phy("rs1 committed", 32, ren_rs1_phy);
        check_bit("rs1 ready", 1'b1, ren_rs1_ready);
        // lanes mixed at random, commit order is checked every cycle
        for (int i = 0; i < 24; i++) begin
            apply_inst(arch_idx_t'($random(seed)), arch_idx_t'($random(seed)),
                       arch_idx_t'($random(seed)), lane_idx_t'($random(seed)));
        end
        idle(`RN_LANE_LAT + 3);
    endtask

    task automatic test_backpressure();
        cur_test = "backpressure";
        do_reset();
        // each lane drains after RN_LANE_LAT cycles so a chain of sixteen keeps flowing
        for (int i = 0; i < `RN_ROB_DEPTH; i++) begin
            apply_inst(arch_idx_t'(i % 7 + 1), arch_idx_t'((i + 6) % 7 + 1), '0,
                       lane_idx_t'(i));
        end
        check_bit("ready after burst", 1'b1, inst_ready);
        idle(`RN_LANE_LAT + 3);
    endtask

    task automatic test_flush();
        logic acc;
        cur_test = "flush";
        do_reset();
        apply_inst(1, 0, 0, 0);
        idle(`RN_LANE_LAT + 3);     // r1 to p32 retires, p1 is free again
        apply_inst(2, 1, 0, 1);
        check_phy("alloc p1", 1, ren_rd_phy);
        apply_inst(1, 2, 0, 0);
        check_phy("alloc p33", 33, ren_rd_phy);
        flush      = 1'b1;
        inst_valid = 1'b1;
        inst_rd    = 4;
        step(acc);                  // inst_ready must be low here
        flush      = 1'b0;
        inst_valid = 1'b0;
        apply_inst(0, 1, 2, 0);
        check_phy("rs1 committed map", 32, ren_rs1_phy);
        check_bit("rs1 ready", 1'b1, ren_rs1_ready);
        check_phy("rs2 committed map", 2, ren_rs2_phy);
        check_bit("rs2 ready", 1'b1, ren_rs2_ready);
        idle(`RN_LANE_LAT + 3);
        apply_inst(5, 0, 0, 1);
        check_phy("rebuilt free list", 1, ren_rd_phy);
        idle(`RN_LANE_LAT + 3);
    endtask

    initial begin
        #((test_cycles + 100) * 10);
        $display("watchdog expired after %0d cycles without finishing the tests", test_cycles + 100);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        flush      = 1'b0;
        inst_valid = 1'b0;
        inst_rd    = '0;
        inst_rs1   = '0;
        inst_rs2   = '0;
        inst_lane  = '0;
        test_reset_state();
        test_rename();
        test_wakeup();
        test_commit();
        test_backpressure();
        test_flush();
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* verilog/exec_lane.sv */
`timescale 1ns/1ps
`include "rename_cfg.svh"

module exec_lane (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  issue_valid,
    input  rename_pkg::arch_idx_t issue_arch,
    input  rename_pkg::phy_idx_t  issue_phy,
    input  rename_pkg::rob_idx_t  issue_rob,
    output logic                  cdb_valid,
    output rename_pkg::arch_idx_t cdb_arch,
    output rename_pkg::phy_idx_t  cdb_phy,
    output rename_pkg::rob_idx_t  cdb_rob
);
    import rename_pkg::*;

    logic [`RN_LANE_LAT-1:0] stg_valid;
    arch_idx_t               stg_arch [`RN_LANE_LAT];
    phy_idx_t                stg_phy [`RN_LANE_LAT];
    rob_idx_t                stg_rob [`RN_LANE_LAT];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            stg_valid <= '0; // drop everything in flight
        end else begin
            stg_valid[0] <= issue_valid;
            for (int i = 1; i < `RN_LANE_LAT; i++) begin
                stg_valid[i] <= stg_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        stg_arch[0] <= issue_arch;
        stg_phy[0]  <= issue_phy;
        stg_rob[0]  <= issue_rob;
        for (int i = 1; i < `RN_LANE_LAT; i++) begin
            stg_arch[i] <= stg_arch[i-1];
            stg_phy[i]  <= stg_phy[i-1];
            stg_rob[i]  <= stg_rob[i-1];
        end
    end

    // last stage drives the bus channel
    assign cdb_valid = stg_valid[`RN_LANE_LAT-1];
    assign cdb_arch  = stg_arch[`RN_LANE_LAT-1];
    assign cdb_phy   = stg_phy[`RN_LANE_LAT-1];
    assign cdb_rob   = stg_rob[`RN_LANE_LAT-1];

endmodule

/* verilog/free_list.sv */
`timescale 1ns/1ps
`include "rename_cfg.svh"

module free_list (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 alloc_en,
    input  logic                 release_en,
    input  rename_pkg::phy_idx_t release_phy,
    input  rename_pkg::phy_idx_t rrf_map [`RN_ARF_DEPTH],
    output rename_pkg::phy_idx_t alloc_phy,
    output logic                 empty
);
    import rename_pkg::*;

    logic [`RN_PRF_DEPTH-1:0] free_q;   // 1 = register available
    logic [`RN_PRF_DEPTH-1:0] rebuilt;

    // everything the committed map does not hold is free after a flush
    always_comb begin
        rebuilt = '1;
        for (int i = 0; i < `RN_ARF_DEPTH; i++) begin
            rebuilt[rrf_map[i]] = 1'b0;
        end
    end

    // lowest index first
    always_comb begin
        alloc_phy = '0;
        for (int i = `RN_PRF_DEPTH - 1; i >= 0; i--) begin
            if (free_q[i])
                alloc_phy = phy_idx_t'(i);
        end
    end

    assign empty = ~|free_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RN_PRF_DEPTH; i++) begin
                free_q[i] <= (i >= `RN_ARF_DEPTH);
            end
        end else if (flush) begin
            free_q <= rebuilt;
        end else begin
            if (alloc_en)
                free_q[alloc_phy] <= 1'b0;
            if (release_en)
                free_q[release_phy] <= 1'b1; // old mapping of a retired instruction
        end
    end

    a_no_double_free: assert property (@(posedge clk) disable iff (rst || flush)
        release_en |-> !free_q[release_phy]);

endmodule

/* verilog/rename_core.sv */
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    input  logic                  inst_valid,
    output logic                  inst_ready,
    input  rename_pkg::arch_idx_t inst_rd,
    input  rename_pkg::arch_idx_t inst_rs1,
    input  rename_pkg::arch_idx_t inst_rs2,
    input  rename_pkg::lane_idx_t inst_lane,

    output logic                  ren_valid,
    output rename_pkg::phy_idx_t  ren_rd_phy,
    output rename_pkg::phy_idx_t  ren_rs1_phy,
    output rename_pkg::phy_idx_t  ren_rs2_phy,
    output logic                  ren_rs1_ready,
    output logic                  ren_rs2_ready,

    output logic [`RN_CDB_WIDTH-1:0] cdb_valid,
    output rename_pkg::phy_idx_t  cdb_phy [`RN_CDB_WIDTH],

    output logic                  commit_valid,
    output rename_pkg::arch_idx_t commit_arch,
    output rename_pkg::phy_idx_t  commit_phy
);
    import rename_pkg::*;

    logic      accept;
    logic      rd_live;     // destination gets a new register
    logic      fl_empty;
    logic      rob_full;
    logic      retire_wr;
    phy_idx_t  fl_phy;
    phy_idx_t  new_phy;
    phy_idx_t  old_phy;
    phy_idx_t  rs1_phy;
    phy_idx_t  rs2_phy;
    logic      rs1_ready;
    logic      rs2_ready;
    rob_idx_t  rob_slot;
    phy_idx_t  commit_old_phy;
    phy_idx_t  rrf_map [`RN_ARF_DEPTH];
    arch_idx_t cdb_arch [`RN_CDB_WIDTH];
    rob_idx_t  cdb_rob [`RN_CDB_WIDTH];

    assign rd_live    = (inst_rd != '0);
    assign inst_ready = !rob_full && (!fl_empty || !rd_live) && !flush;
    assign accept     = inst_valid && inst_ready;
    assign new_phy    = rd_live ? fl_phy : '0;
    assign retire_wr  = commit_valid && (commit_arch != '0);

    rat rat_inst (
        .clk(clk), .rst(rst), .flush(flush), .rrf_map(rrf_map),
        .read_arch0(inst_rs1), .read_arch1(inst_rs2), .dest_arch(inst_rd),
        .write_en(accept && rd_live), .write_phy(fl_phy),
        .cdb_valid(cdb_valid), .cdb_arch(cdb_arch), .cdb_phy(cdb_phy),
        .read_phy0(rs1_phy), .read_phy1(rs2_phy), .old_phy(old_phy),
        .read_ready0(rs1_ready), .read_ready1(rs2_ready)
    );

    rrf rrf_inst (
        .clk(clk), .rst(rst), .commit_en(retire_wr),
        .commit_arch(commit_arch), .commit_phy(commit_phy), .rrf_map(rrf_map)
    );

    free_list free_list_inst (
        .clk(clk), .rst(rst), .flush(flush), .alloc_en(accept && rd_live),
        .release_en(retire_wr), .release_phy(commit_old_phy), .rrf_map(rrf_map),
        .alloc_phy(fl_phy), .empty(fl_empty)
    );

    rob rob_inst (
        .clk(clk), .rst(rst), .flush(flush), .alloc_en(accept),
        .alloc_arch(inst_rd), .alloc_phy(new_phy), .alloc_old_phy(old_phy),
        .alloc_idx(rob_slot), .full(rob_full), .cdb_valid(cdb_valid), .cdb_rob(cdb_rob),
        .commit_valid(commit_valid), .commit_arch(commit_arch),
        .commit_phy(commit_phy), .commit_old_phy(commit_old_phy)
    );

    for (genvar i = 0; i < `RN_CDB_WIDTH; i++) begin : g_lane
        exec_lane exec_lane_inst (
            .clk(clk), .rst(rst), .flush(flush),
            .issue_valid(accept && inst_lane == lane_idx_t'(i)),
            .issue_arch(inst_rd), .issue_phy(new_phy), .issue_rob(rob_slot),
            .cdb_valid(cdb_valid[i]), .cdb_arch(cdb_arch[i]),
            .cdb_phy(cdb_phy[i]), .cdb_rob(cdb_rob[i])
        );
    end

    always_ff @(posedge clk) begin
        if (rst)
            ren_valid <= 1'b0;
        else
            ren_valid <= accept; // one-cycle pulse per instruction
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ren_rd_phy    <= new_phy;
            ren_rs1_phy   <= rs1_phy;
            ren_rs2_phy   <= rs2_phy;
            ren_rs1_ready <= rs1_ready;
            ren_rs2_ready <= rs2_ready;
        end
    end

endmodule

/* verilog/rob.sv */
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rob (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    input  logic                  alloc_en,
    input  rename_pkg::arch_idx_t alloc_arch,
    input  rename_pkg::phy_idx_t  alloc_phy,
    input  rename_pkg::phy_idx_t  alloc_old_phy,
    output rename_pkg::rob_idx_t  alloc_idx,
    output logic                  full,

    input  logic [`RN_CDB_WIDTH-1:0] cdb_valid,
    input  rename_pkg::rob_idx_t  cdb_rob [`RN_CDB_WIDTH],

    output logic                  commit_valid,
    output rename_pkg::arch_idx_t commit_arch,
    output rename_pkg::phy_idx_t  commit_phy,
    output rename_pkg::phy_idx_t  commit_old_phy
);
    import rename_pkg::*;

    arch_idx_t                ent_arch [`RN_ROB_DEPTH];
    phy_idx_t                 ent_phy [`RN_ROB_DEPTH];
    phy_idx_t                 ent_old [`RN_ROB_DEPTH];
    logic [`RN_ROB_DEPTH-1:0] ent_done;

    rob_idx_t head;
    rob_idx_t tail;
    rob_cnt_t count;

    // slot lies between head and tail
    function automatic logic slot_live(rob_idx_t slot, rob_idx_t hd, rob_cnt_t cnt);
        rob_idx_t ofs;
        ofs = slot - hd;
        return rob_cnt_t'(ofs) < cnt;
    endfunction

    assign alloc_idx = tail;
    assign full      = (count == rob_cnt_t'(`RN_ROB_DEPTH));

    assign commit_valid   = (count != '0) && ent_done[head] && !flush;
    assign commit_arch    = ent_arch[head];
    assign commit_phy     = ent_phy[head];
    assign commit_old_phy = ent_old[head];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            ent_done <= '0;
        end else begin
            for (int i = 0; i < `RN_CDB_WIDTH; i++) begin
                if (cdb_valid[i])
                    ent_done[cdb_rob[i]] <= 1'b1;
            end
            if (alloc_en) begin
                ent_done[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (commit_valid)
                head <= head + 1'b1;
            case ({alloc_en, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            ent_arch[tail] <= alloc_arch;
            ent_phy[tail]  <= alloc_phy;
            ent_old[tail]  <= alloc_old_phy;
        end
    end

    for (genvar i = 0; i < `RN_CDB_WIDTH; i++) begin : g_cdb_chk
        a_cdb_live: assert property (@(posedge clk) disable iff (rst || flush)
            cdb_valid[i] |-> slot_live(cdb_rob[i], head, count));
    end

endmodule
